/* files.f */
+incdir+tb
verilog/rob_pkg.sv
verilog/rob_pointer_ctrl.sv
verilog/rob_entry_table.sv
verilog/rob_squash_unit.sv
verilog/rob_retire_stage.sv
verilog/rob_top.sv
tb/rob_properties.sv
tb/rob_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module rob_tb -Mdir obj_dir -o rob_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rob_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1

/* tb/rob_properties.sv */
module rob_properties import rob_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       dispatch_ready_i,
    input  logic       mispredict_i,
    input  logic       commit_ready_i,
    input  logic       commit_valid_i,
    input  logic       commit_rd_wen_i,
    input  arch_reg_t  commit_rd_arch_i,
    input  phys_reg_t  commit_new_prf_i,
    input  phys_reg_t  commit_old_prf_i,
    input  data_t      commit_value_i,
    input  logic       commit_exception_i,
    input  logic       squash_free_valid_i
);

    // count of failed assertions
    int unsigned violations = 0;

    // stalled commit slot keeps its contents
    commit_hold: assert property (
        @(posedge clock) disable iff (reset)
        (commit_valid_i && !commit_ready_i) |=>
            (commit_valid_i && $stable({commit_rd_wen_i, commit_rd_arch_i,
                                        commit_new_prf_i, commit_old_prf_i,
                                        commit_value_i, commit_exception_i}))
    ) else begin
        $error("commit slot changed while stalled");
        violations++;
    end

    // free-list report is a single pulse
    free_pulse: assert property (
        @(posedge clock) disable iff (reset)
        squash_free_valid_i |=> !squash_free_valid_i
    ) else begin
        $error("squash_free_valid_o high for two cycles");
        violations++;
    end

    // no allocation during recovery
    no_dispatch_on_mispredict: assert property (
        @(posedge clock) disable iff (reset)
        mispredict_i |-> !dispatch_ready_i
    ) else begin
        $error("dispatch_ready_o high in a mispredict cycle");
        violations++;
    end

endmodule

bind rob_top rob_properties i_properties (
    .clock               (clock),
    .reset               (reset),
    .dispatch_ready_i    (dispatch_ready_o),
    .mispredict_i        (mispredict_i),
    .commit_ready_i      (commit_ready_i),
    .commit_valid_i      (commit_valid_o),
    .commit_rd_wen_i     (commit_rd_wen_o),
    .commit_rd_arch_i    (commit_rd_arch_o),
    .commit_new_prf_i    (commit_new_prf_o),
    .commit_old_prf_i    (commit_old_prf_o),
    .commit_value_i      (commit_value_o),
    .commit_exception_i  (commit_exception_o),
    .squash_free_valid_i (squash_free_valid_o)
);

/* tb/rob_model.svh */
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// ======================================================================
// reference model of the reorder buffer
// ======================================================================

// one instruction as the model tracks it
typedef struct packed {
    rob_idx_t  idx;
    logic      rd_wen;
    arch_reg_t rd_arch;
    phys_reg_t new_prf;
    phys_reg_t old_prf;
    logic      done;
    data_t     value;
    logic      exc;
} model_entry_t;

// entries still in the table, oldest first
model_entry_t live_q[$];
// retired entries sitting in the commit slot
model_entry_t commit_q[$];
// index the next dispatch should get
rob_idx_t     model_tail;
// free-list report due one cycle after a squash
logic         exp_free_valid;
phys_mask_t   exp_free_mask;

task automatic clear_model();
    live_q.delete();
    commit_q.delete();
    model_tail     = '0;
    exp_free_valid = 1'b0;
    exp_free_mask  = '0;
endtask

task automatic allocate_entry(input logic wen, input arch_reg_t arch,
                              input phys_reg_t new_prf, input phys_reg_t old_prf);
    model_entry_t e;
    e         = '0;
    e.idx     = model_tail;
    e.rd_wen  = wen;
    e.rd_arch = arch;
    e.new_prf = new_prf;
    e.old_prf = old_prf;
    live_q.push_back(e);
    // wraps at the buffer depth
    model_tail = rob_idx_t'(model_tail + 1);
endtask

task automatic complete_entry(input rob_idx_t idx, input data_t value, input logic exc);
    foreach (live_q[i]) begin
        if (live_q[i].idx == idx) begin
            live_q[i].done  = 1'b1;
            live_q[i].value = value;
            live_q[i].exc   = exc;
        end
    end
endtask

// head leaves the table and enters the commit slot
task automatic retire_head();
    commit_q.push_back(live_q.pop_front());
endtask

// drop everything younger than the branch at position pos
task automatic squash_after(input int pos);
    phys_mask_t mask;
    int         last;
    mask       = '0;
    model_tail = rob_idx_t'(live_q[pos].idx + 1);
    while (live_q.size() > pos + 1) begin
        last = live_q.size() - 1;
        if (live_q[last].rd_wen) begin
            mask[live_q[last].new_prf] = 1'b1;
        end
        void'(live_q.pop_back());
    end
    exp_free_mask = mask;
endtask

`endif

/* tb/rob_tb.sv */
module rob_tb import rob_pkg::*; ();

    localparam int SEED_INIT     = 23426;
    localparam int NUM_CYCLES    = 4000;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int SAMPLE_DELAY  = 50;
    // stimulus phase length in cycles
    // commit stalled for the first STALL_LEN of each phase
    localparam int PHASE_LEN     = 200;
    localparam int STALL_LEN     = 50;

    // ======================================================================
    // DUT signals
    // ======================================================================

    logic                    clock;
    logic                    reset;
    logic                    dispatch_valid_i;
    logic                    dispatch_rd_wen_i;
    arch_reg_t               dispatch_rd_arch_i;
    phys_reg_t               dispatch_new_prf_i;
    phys_reg_t               dispatch_old_prf_i;
    logic                    dispatch_ready_o;
    rob_idx_t                dispatch_idx_o;
    logic     [WB_PORTS-1:0] wb_valid_i;
    rob_idx_t [WB_PORTS-1:0] wb_idx_i;
    data_t    [WB_PORTS-1:0] wb_value_i;
    logic     [WB_PORTS-1:0] wb_exception_i;
    logic                    commit_valid_o;
    logic                    commit_rd_wen_o;
    arch_reg_t               commit_rd_arch_o;
    phys_reg_t               commit_new_prf_o;
    phys_reg_t               commit_old_prf_o;
    data_t                   commit_value_o;
    logic                    commit_exception_o;
    logic                    commit_ready_i;
    logic                    mispredict_i;
    rob_idx_t                mispredict_idx_i;
    logic                    squash_free_valid_o;
    phys_mask_t              squash_free_mask_o;

    integer seed;
    int     errors;
    int     commits;
    int     squashes;
    int     full_cycles;
    int     drain_cycles;
    bit     last_mispredict;

    `include "rob_model.svh"

    rob_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_that(input bit ok, input string msg);
        assert (ok) else begin
            $display("FAILED %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // ======================================================================
    // one clock cycle of drive, sample and model update
    // ======================================================================

    task automatic run_cycle(input int cycle, input bit drain);
        int           cand[$];
        int           pick;
        int           mp_pos;
        bit           mp;
        bit           stall;
        bit           ready_exp;
        bit           do_retire;
        model_entry_t slot;

        #DRIVE_DELAY;
        stall  = !drain && ((cycle % PHASE_LEN) < STALL_LEN);
        // branch recovery at most every other cycle
        mp     = 1'b0;
        mp_pos = 0;
        if (!drain && !stall && !last_mispredict && (live_q.size() > 0)) begin
            if ($unsigned($random(seed)) % 24 == 0) begin
                mp     = 1'b1;
                mp_pos = $unsigned($random(seed)) % live_q.size();
            end
        end
        mispredict_i     = mp;
        mispredict_idx_i = mp ? live_q[mp_pos].idx : '0;

        // completions on distinct issued entries
        foreach (live_q[i]) begin
            if (!live_q[i].done) begin
                cand.push_back(i);
            end
        end
        for (int p = 0; p < WB_PORTS; p++) begin
            wb_valid_i[p]     = 1'b0;
            wb_idx_i[p]       = '0;
            wb_value_i[p]     = '0;
            wb_exception_i[p] = 1'b0;
            if ((cand.size() > 0) && (drain || ($unsigned($random(seed)) % 2 == 0))) begin
                pick              = $unsigned($random(seed)) % cand.size();
                wb_valid_i[p]     = 1'b1;
                wb_idx_i[p]       = live_q[cand[pick]].idx;
                wb_value_i[p]     = data_t'($random(seed));
                wb_exception_i[p] = ($unsigned($random(seed)) % 8 == 0);
                cand.delete(pick);
            end
        end

        dispatch_valid_i   = !drain && ($unsigned($random(seed)) % 4 != 0);
        dispatch_rd_wen_i  = ($unsigned($random(seed)) % 4 != 0);
        dispatch_rd_arch_i = arch_reg_t'($random(seed));
        dispatch_new_prf_i = phys_reg_t'($random(seed));
        dispatch_old_prf_i = phys_reg_t'($random(seed));

        // stalled phases fill the buffer
        if (drain) begin
            commit_ready_i = 1'b1;
        end else if (stall) begin
            commit_ready_i = 1'b0;
        end else begin
            commit_ready_i = ($unsigned($random(seed)) % 4 != 0);
        end

        #(SAMPLE_DELAY - DRIVE_DELAY);
        ready_exp = (live_q.size() < ROB_DEPTH) && !mp;
        if (live_q.size() == ROB_DEPTH) begin
            full_cycles++;
        end
        check_that(dispatch_ready_o == ready_exp,
                   $sformatf("dispatch_ready_o %0b, expected %0b with %0d live",
                             dispatch_ready_o, ready_exp, live_q.size()));
        check_that(dispatch_idx_o == model_tail,
                   $sformatf("dispatch_idx_o %0d, expected %0d", dispatch_idx_o, model_tail));
        check_that(commit_valid_o == (commit_q.size() > 0),
                   $sformatf("commit_valid_o %0b, expected %0b",
                             commit_valid_o, commit_q.size() > 0));
        if (commit_q.size() > 0) begin
            slot = commit_q[0];
            // shown as rd/prf/value/exception
            check_that({commit_rd_wen_o, commit_rd_arch_o, commit_new_prf_o,
                        commit_old_prf_o, commit_value_o, commit_exception_o} ==
                       {slot.rd_wen, slot.rd_arch, slot.new_prf,
                        slot.old_prf, slot.value, slot.exc},
                       $sformatf("entry %0d commit %0d/%0d/%h/%0b, expected %0d/%0d/%h/%0b",
                                 slot.idx, commit_rd_arch_o, commit_new_prf_o,
                                 commit_value_o, commit_exception_o, slot.rd_arch,
                                 slot.new_prf, slot.value, slot.exc));
        end
        check_that(squash_free_valid_o == exp_free_valid,
                   $sformatf("squash_free_valid_o %0b, expected %0b",
                             squash_free_valid_o, exp_free_valid));
        if (exp_free_valid) begin
            check_that(squash_free_mask_o == exp_free_mask,
                       $sformatf("squash_free_mask_o %h, expected %h",
                                 squash_free_mask_o, exp_free_mask));
        end

        // model the coming edge with the oldest effects first
        exp_free_valid = mp;
        do_retire = (live_q.size() > 0) && live_q[0].done && !mp &&
                    ((commit_q.size() == 0) || commit_ready_i);
        if ((commit_q.size() > 0) && commit_ready_i) begin
            void'(commit_q.pop_front());
            commits++;
        end
        if (do_retire) begin
            retire_head();
        end
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_valid_i[p]) begin
                complete_entry(wb_idx_i[p], wb_value_i[p], wb_exception_i[p]);
            end
        end
        // squash after completions so it wins
        if (mp) begin
            squash_after(mp_pos);
            squashes++;
        end
        if (dispatch_valid_i && ready_exp) begin
            allocate_entry(dispatch_rd_wen_i, dispatch_rd_arch_i,
                           dispatch_new_prf_i, dispatch_old_prf_i);
        end
        last_mispredict = mp;
        @(posedge clock);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        seed               = SEED_INIT;
        errors             = 0;
        commits            = 0;
        squashes           = 0;
        full_cycles        = 0;
        last_mispredict    = 1'b0;
        reset              = 1'b1;
        dispatch_valid_i   = 1'b0;
        dispatch_rd_wen_i  = 1'b0;
        dispatch_rd_arch_i = '0;
        dispatch_new_prf_i = '0;
        dispatch_old_prf_i = '0;
        wb_valid_i         = '0;
        wb_idx_i           = '0;
        wb_value_i         = '0;
        wb_exception_i     = '0;
        commit_ready_i     = 1'b0;
        mispredict_i       = 1'b0;
        mispredict_idx_i   = '0;
        clear_model();

        repeat (5) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        // idle state right after reset
        #(SAMPLE_DELAY - DRIVE_DELAY);
        check_that(!commit_valid_o, "commit_valid_o high after reset");
        check_that(!squash_free_valid_o, "squash_free_valid_o high after reset");
        check_that(dispatch_ready_o, "dispatch_ready_o low after reset");
        check_that(dispatch_idx_o == '0,
                   $sformatf("dispatch_idx_o %0d after reset, expected 0", dispatch_idx_o));
        @(posedge clock);

        for (int c = 0; c < NUM_CYCLES; c++) begin
            run_cycle(c, 1'b0);
        end

        // finish all outstanding work
        drain_cycles = 0;
        while (((live_q.size() != 0) || (commit_q.size() != 0)) &&
               (drain_cycles < DRAIN_TIMEOUT)) begin
            run_cycle(drain_cycles, 1'b1);
            drain_cycles++;
        end
        if ((live_q.size() != 0) || (commit_q.size() != 0)) begin
            $display("ERROR: buffer did not drain within %0d cycles", DRAIN_TIMEOUT);
            errors++;
        end

        // stimulus must have reached the interesting cases
        assert (full_cycles > 0) else begin
            $display("ERROR: the buffer never became full");
            errors++;
        end
        assert (squashes > 0) else begin
            $display("ERROR: no mispredict was ever issued");
            errors++;
        end

        // failures seen by the bound assertions
        errors += int'(i_dut.i_properties.violations);

        $display("errors %0d, commits %0d, squashes %0d, full cycles %0d",
                 errors, commits, squashes, full_cycles);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/rob_entry_table.sv */
module rob_entry_table import rob_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,

    // allocation at the tail
    input  logic                           alloc_i,
    input  rob_idx_t                       tail_i,
    input  logic                           dispatch_rd_wen_i,
    input  arch_reg_t                      dispatch_rd_arch_i,
    input  phys_reg_t                      dispatch_new_prf_i,
    input  phys_reg_t                      dispatch_old_prf_i,

    // completion reports in any order
    input  logic      [WB_PORTS-1:0]       wb_valid_i,
    input  rob_idx_t  [WB_PORTS-1:0]       wb_idx_i,
    input  data_t     [WB_PORTS-1:0]       wb_value_i,
    input  logic      [WB_PORTS-1:0]       wb_exception_i,

    // retirement at the head
    input  logic                           retire_i,
    input  rob_idx_t                       head_i,

    // entries killed by a mispredict
    input  logic      [ROB_DEPTH-1:0]      squash_mask_i,

    // whole-table views for the squash unit
    output entry_status_t [ROB_DEPTH-1:0]  status_vec_o,
    output phys_reg_t [ROB_DEPTH-1:0]      new_prf_vec_o,
    output logic      [ROB_DEPTH-1:0]      rd_wen_vec_o,

    // head entry for the retire stage
    output entry_status_t                  head_status_o,
    output logic                           head_rd_wen_o,
    output arch_reg_t                      head_rd_arch_o,
    output phys_reg_t                      head_new_prf_o,
    output phys_reg_t                      head_old_prf_o,
    output data_t                          head_value_o,
    output logic                           head_exception_o
);

    // ======================================================================
    // storage
    // ======================================================================

    entry_status_t [ROB_DEPTH-1:0] status_q;
    logic          [ROB_DEPTH-1:0] rd_wen_q;
    phys_reg_t     [ROB_DEPTH-1:0] new_prf_q;
    arch_reg_t                     rd_arch_q   [ROB_DEPTH];
    phys_reg_t                     old_prf_q   [ROB_DEPTH];
    data_t                         value_q     [ROB_DEPTH];
    logic                          exception_q [ROB_DEPTH];

    // per-entry status
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                status_q[i] <= ENTRY_FREE;
            end
        end else begin
            if (alloc_i) begin
                status_q[tail_i] <= ENTRY_ISSUED;
            end
            // completions from both ports
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb_valid_i[p]) begin
                    status_q[wb_idx_i[p]] <= ENTRY_DONE;
                end
            end
            if (retire_i) begin
                status_q[head_i] <= ENTRY_FREE;
            end
            // squash last so it overrides everything above
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (squash_mask_i[i]) begin
                    status_q[i] <= ENTRY_FREE;
                end
            end
        end
    end

    // payload fields
    always_ff @(posedge clock) begin
        if (alloc_i) begin
            rd_wen_q[tail_i]  <= dispatch_rd_wen_i;
            rd_arch_q[tail_i] <= dispatch_rd_arch_i;
            new_prf_q[tail_i] <= dispatch_new_prf_i;
            old_prf_q[tail_i] <= dispatch_old_prf_i;
        end
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_valid_i[p]) begin
                value_q[wb_idx_i[p]]     <= wb_value_i[p];
                exception_q[wb_idx_i[p]] <= wb_exception_i[p];
            end
        end
    end

    // ======================================================================
    // read side
    // ======================================================================

    assign status_vec_o  = status_q;
    assign new_prf_vec_o = new_prf_q;
    assign rd_wen_vec_o  = rd_wen_q;

    assign head_status_o    = status_q[head_i];
    assign head_rd_wen_o    = rd_wen_q[head_i];
    assign head_rd_arch_o   = rd_arch_q[head_i];
    assign head_new_prf_o   = new_prf_q[head_i];
    assign head_old_prf_o   = old_prf_q[head_i];
    assign head_value_o     = value_q[head_i];
    assign head_exception_o = exception_q[head_i];

endmodule

/* verilog/rob_pkg.sv */
package rob_pkg;

    // ======================================================================
    // sizes
    // ======================================================================

    // entries in the buffer
    localparam int ROB_DEPTH = 16;
    // architectural register file
    localparam int ARCH_REGS = 32;
    // physical register file
    localparam int PHYS_REGS = 64;
    // result width
    localparam int XLEN      = 32;
    // writeback ports into the buffer
    localparam int WB_PORTS  = 2;

    // derived widths
    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);
    localparam int ARCH_REG_W = $clog2(ARCH_REGS);
    localparam int PHYS_REG_W = $clog2(PHYS_REGS);

    // ======================================================================
    // types
    // ======================================================================

    // slot index, wraps at ROB_DEPTH
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    // occupancy, one extra bit so that a full buffer fits
    typedef logic [ROB_IDX_W:0]    rob_count_t;

    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;
    typedef logic [XLEN-1:0]       data_t;

    // one bit per physical register, for the free list
    typedef logic [PHYS_REGS-1:0]  phys_mask_t;

    // per-entry life cycle
    typedef enum logic [1:0] {
        ENTRY_FREE   = 2'd0,
        ENTRY_ISSUED = 2'd1,
        ENTRY_DONE   = 2'd2
    } entry_status_t;

endpackage

/* verilog/rob_pointer_ctrl.sv */
module rob_pointer_ctrl import rob_pkg::*; (
    input  logic       clock,
    input  logic       reset,

    // dispatch side
    input  logic       dispatch_valid_i,
    output logic       dispatch_ready_o,
    output logic       alloc_o,

    // branch recovery
    input  logic       mispredict_i,
    input  rob_idx_t   mispredict_idx_i,
    input  rob_count_t squash_count_i,

    // retire side
    input  logic       retire_i,

    output rob_idx_t   head_o,
    output rob_idx_t   tail_o
);

    rob_idx_t   head_q;
    rob_idx_t   tail_q;
    rob_count_t count_q;
    logic       full;

    assign full = (count_q == rob_count_t'(ROB_DEPTH));

    // no allocation while recovering from a mispredict
    assign dispatch_ready_o = !full && !mispredict_i;
    assign alloc_o          = dispatch_valid_i && dispatch_ready_o;

    assign head_o = head_q;
    assign tail_o = tail_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // oldest entry leaves
            if (retire_i) begin
                head_q <= rob_idx_t'(head_q + 1'b1);
            end

            if (mispredict_i) begin
                // tail snaps back to just past the branch
                tail_q  <= rob_idx_t'(mispredict_idx_i + 1'b1);
                count_q <= rob_count_t'(count_q - squash_count_i);
            end else begin
                if (alloc_o) begin
                    tail_q <= rob_idx_t'(tail_q + 1'b1);
                end
                // alloc and retire in the same cycle cancel out
                case ({alloc_o, retire_i})
                    2'b10:   count_q <= rob_count_t'(count_q + 1'b1);
                    2'b01:   count_q <= rob_count_t'(count_q - 1'b1);
                    default: count_q <= count_q;
                endcase
            end
        end
    end

endmodule

/* verilog/rob_retire_stage.sv */
module rob_retire_stage import rob_pkg::*; (
    input  logic          clock,
    input  logic          reset,

    // head entry of the table
    input  entry_status_t head_status_i,
    input  logic          head_rd_wen_i,
    input  arch_reg_t     head_rd_arch_i,
    input  phys_reg_t     head_new_prf_i,
    input  phys_reg_t     head_old_prf_i,
    input  data_t         head_value_i,
    input  logic          head_exception_i,

    input  logic          mispredict_i,
    input  logic          commit_ready_i,

    output logic          retire_o,

    // registered commit slot
    output logic          commit_valid_o,
    output logic          commit_rd_wen_o,
    output arch_reg_t     commit_rd_arch_o,
    output phys_reg_t     commit_new_prf_o,
    output phys_reg_t     commit_old_prf_o,
    output data_t         commit_value_o,
    output logic          commit_exception_o
);

    logic slot_free;

    // slot empty now, or emptied at this edge
    assign slot_free = !commit_valid_o || commit_ready_i;

    // in order only, and never during recovery
    assign retire_o = (head_status_i == ENTRY_DONE) && slot_free && !mispredict_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid_o <= 1'b0;
        end else if (retire_o) begin
            commit_valid_o <= 1'b1;
        end else if (commit_ready_i) begin
            commit_valid_o <= 1'b0;
        end
    end

    // data held stable under back-pressure
    always_ff @(posedge clock) begin
        if (retire_o) begin
            commit_rd_wen_o    <= head_rd_wen_i;
            commit_rd_arch_o   <= head_rd_arch_i;
            commit_new_prf_o   <= head_new_prf_i;
            commit_old_prf_o   <= head_old_prf_i;
            commit_value_o     <= head_value_i;
            commit_exception_o <= head_exception_i;
        end
    end

endmodule

/* verilog/rob_squash_unit.sv */
module rob_squash_unit import rob_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,

    input  logic                          mispredict_i,
    input  rob_idx_t                      mispredict_idx_i,
    input  rob_idx_t                      head_i,
    input  rob_idx_t                      tail_i,

    input  entry_status_t [ROB_DEPTH-1:0] status_vec_i,
    input  phys_reg_t [ROB_DEPTH-1:0]     new_prf_vec_i,
    input  logic      [ROB_DEPTH-1:0]     rd_wen_vec_i,

    output logic      [ROB_DEPTH-1:0]     squash_mask_o,
    output rob_count_t                    squash_count_o,

    // to the free list, one cycle after the mispredict
    output logic                          squash_free_valid_o,
    output phys_mask_t                    squash_free_mask_o
);

    // number of entries strictly younger than the branch
    rob_idx_t   kill_span;
    // distance of each slot past the branch
    rob_idx_t   branch_off [ROB_DEPTH];
    rob_count_t live_count;
    rob_count_t survivors;
    phys_mask_t free_mask_d;

    assign kill_span = rob_idx_t'(tail_i - mispredict_idx_i - 1'b1);

    always_comb begin
        squash_mask_o = '0;
        live_count    = '0;
        free_mask_d   = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            branch_off[i] = rob_idx_t'(rob_idx_t'(i) - mispredict_idx_i - 1'b1);
            if (status_vec_i[i] != ENTRY_FREE) begin
                live_count = rob_count_t'(live_count + 1'b1);
                // younger than the branch and not past the tail
                if (mispredict_i && (branch_off[i] < kill_span)) begin
                    squash_mask_o[i] = 1'b1;
                end
            end
            // only register-writing entries own a new physical reg
            if (squash_mask_o[i] && rd_wen_vec_i[i]) begin
                free_mask_d[new_prf_vec_i[i]] = 1'b1;
            end
        end
    end

    // branch itself and everything older stay
    assign survivors      = rob_count_t'({1'b0, rob_idx_t'(mispredict_idx_i - head_i)} + 1'b1);
    assign squash_count_o = rob_count_t'(live_count - survivors);

    always_ff @(posedge clock) begin
        if (reset) begin
            squash_free_valid_o <= 1'b0;
        end else begin
            squash_free_valid_o <= mispredict_i;
        end
    end

    // bitmap held until the next mispredict
    always_ff @(posedge clock) begin
        if (mispredict_i) begin
            squash_free_mask_o <= free_mask_d;
        end
    end

endmodule

/* verilog/rob_top.sv */
module rob_top import rob_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,

    // dispatch
    input  logic                     dispatch_valid_i,
    input  logic                     dispatch_rd_wen_i,
    input  arch_reg_t                dispatch_rd_arch_i,
    input  phys_reg_t                dispatch_new_prf_i,
    input  phys_reg_t                dispatch_old_prf_i,
    output logic                     dispatch_ready_o,
    output rob_idx_t                 dispatch_idx_o,

    // writeback
    input  logic     [WB_PORTS-1:0]  wb_valid_i,
    input  rob_idx_t [WB_PORTS-1:0]  wb_idx_i,
    input  data_t    [WB_PORTS-1:0]  wb_value_i,
    input  logic     [WB_PORTS-1:0]  wb_exception_i,

    // commit
    output logic                     commit_valid_o,
    output logic                     commit_rd_wen_o,
    output arch_reg_t                commit_rd_arch_o,
    output phys_reg_t                commit_new_prf_o,
    output phys_reg_t                commit_old_prf_o,
    output data_t                    commit_value_o,
    output logic                     commit_exception_o,
    input  logic                     commit_ready_i,

    // mispredict recovery
    input  logic                     mispredict_i,
    input  rob_idx_t                 mispredict_idx_i,
    output logic                     squash_free_valid_o,
    output phys_mask_t               squash_free_mask_o
);

    // ======================================================================
    // internal nets
    // ======================================================================

    logic                          alloc;
    logic                          retire;
    rob_idx_t                      head;
    rob_idx_t                      tail;
    logic          [ROB_DEPTH-1:0] squash_mask;
    rob_count_t                    squash_count;
    entry_status_t [ROB_DEPTH-1:0] status_vec;
    phys_reg_t     [ROB_DEPTH-1:0] new_prf_vec;
    logic          [ROB_DEPTH-1:0] rd_wen_vec;

    entry_status_t head_status;
    logic          head_rd_wen;
    arch_reg_t     head_rd_arch;
    phys_reg_t     head_new_prf;
    phys_reg_t     head_old_prf;
    data_t         head_value;
    logic          head_exception;

    // next accepted instruction lands at the tail
    assign dispatch_idx_o = tail;

    // ======================================================================
    // units
    // ======================================================================

    rob_pointer_ctrl i_pointer_ctrl (
        .clock            (clock),
        .reset            (reset),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_ready_o (dispatch_ready_o),
        .alloc_o          (alloc),
        .mispredict_i     (mispredict_i),
        .mispredict_idx_i (mispredict_idx_i),
        .squash_count_i   (squash_count),
        .retire_i         (retire),
        .head_o           (head),
        .tail_o           (tail)
    );

    rob_entry_table i_entry_table (
        .clock              (clock),
        .reset              (reset),
        .alloc_i            (alloc),
        .tail_i             (tail),
        .dispatch_rd_wen_i  (dispatch_rd_wen_i),
        .dispatch_rd_arch_i (dispatch_rd_arch_i),
        .dispatch_new_prf_i (dispatch_new_prf_i),
        .dispatch_old_prf_i (dispatch_old_prf_i),
        .wb_valid_i         (wb_valid_i),
        .wb_idx_i           (wb_idx_i),
        .wb_value_i         (wb_value_i),
        .wb_exception_i     (wb_exception_i),
        .retire_i           (retire),
        .head_i             (head),
        .squash_mask_i      (squash_mask),
        .status_vec_o       (status_vec),
        .new_prf_vec_o      (new_prf_vec),
        .rd_wen_vec_o       (rd_wen_vec),
        .head_status_o      (head_status),
        .head_rd_wen_o      (head_rd_wen),
        .head_rd_arch_o     (head_rd_arch),
        .head_new_prf_o     (head_new_prf),
        .head_old_prf_o     (head_old_prf),
        .head_value_o       (head_value),
        .head_exception_o   (head_exception)
    );

    rob_squash_unit i_squash_unit (
        .clock               (clock),
        .reset               (reset),
        .mispredict_i        (mispredict_i),
        .mispredict_idx_i    (mispredict_idx_i),
        .head_i              (head),
        .tail_i              (tail),
        .status_vec_i        (status_vec),
        .new_prf_vec_i       (new_prf_vec),
        .rd_wen_vec_i        (rd_wen_vec),
        .squash_mask_o       (squash_mask),
        .squash_count_o      (squash_count),
        .squash_free_valid_o (squash_free_valid_o),
        .squash_free_mask_o  (squash_free_mask_o)
    );

    rob_retire_stage i_retire_stage (
        .clock              (clock),
        .reset              (reset),
        .head_status_i      (head_status),
        .head_rd_wen_i      (head_rd_wen),
        .head_rd_arch_i     (head_rd_arch),
        .head_new_prf_i     (head_new_prf),
        .head_old_prf_i     (head_old_prf),
        .head_value_i       (head_value),
        .head_exception_i   (head_exception),
        .mispredict_i       (mispredict_i),
        .commit_ready_i     (commit_ready_i),
        .retire_o           (retire),
        .commit_valid_o     (commit_valid_o),
        .commit_rd_wen_o    (commit_rd_wen_o),
        .commit_rd_arch_o   (commit_rd_arch_o),
        .commit_new_prf_o   (commit_new_prf_o),
        .commit_old_prf_o   (commit_old_prf_o),
        .commit_value_o     (commit_value_o),
        .commit_exception_o (commit_exception_o)
    );

endmodule
